// File: vlog.f
rtl/hbDecimPkg.sv
rtl/sampleInterleaver.sv
rtl/tapSlice.sv
rtl/halfBandCore.sv
rtl/roundSaturate.sv
rtl/halfBandDecimator.sv
dv/halfBandDecimatorChecker.sv
dv/halfBandDecimatorTb.sv

// File: run.sh
#!/bin/sh
# Build and run the half-band decimator testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module halfBandDecimatorTb -o halfBandDecimatorSim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

# Keep running past checker errors so the testbench reports them
./obj_dir/halfBandDecimatorSim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: dv/halfBandDecimatorTb.sv
`timescale 1ns/1ps

module halfBandDecimatorTb;

    //////////////////////////////////////////////////////////////////////
    // Constants and stimulus table
    //////////////////////////////////////////////////////////////////////

    localparam int NumTaps = 47;
    // outStrobe seen this many cycles after the strobe cycle
    localparam int OutLatency = 6;
    localparam int DrainTimeout = 40;
    localparam int KindImpulse = 0;
    localparam int KindConstant = 1;
    localparam int KindRandom = 2;
    localparam int NumRows = 9;

    // Pair coefficients with the outermost pair first
    localparam int PairCoef [12] = '{-8, 27, -68, 146, -281, 499,
        -837, 1353, -2161, 3547, -6561, 20727};

    // Segment kind, channel amplitudes, pair count, strobe spacing
    localparam int RowKind [NumRows] = '{KindImpulse, KindImpulse, KindConstant,
        KindConstant, KindConstant, KindConstant, KindConstant, KindRandom, KindRandom};
    localparam int RowAmp0 [NumRows] = '{16383, -16384, 4000, 16383, -16384, 5, -5,
        16384, 16384};
    localparam int RowAmp1 [NumRows] = '{0, 12000, -3000, 16383, -16384, 3, -3,
        16384, 16384};
    localparam int RowPairs [NumRows] = '{50, 50, 60, 60, 60, 60, 60, 80, 80};
    localparam int RowGap [NumRows] = '{3, 4, 2, 3, 2, 2, 2, 2, 5};
    // Settled small constants of opposite sign
    localparam int MirrorPos = 5;
    localparam int MirrorNeg = 6;

    logic Clk = 1'b0;
    logic Reset;
    logic inStrobe;
    logic signed [hbDecimPkg::SampleWidth-1:0] in0;
    logic signed [hbDecimPkg::SampleWidth-1:0] in1;
    logic [hbDecimPkg::OutWidth-1:0] out0;
    logic [hbDecimPkg::OutWidth-1:0] out1;
    logic overflow0;
    logic overflow1;
    logic outStrobe;

    // Model histories with index 0 newest
    int hist [2][NumTaps];
    bit refPhase = 1'b0;
    int unsigned lcgState = 32'hf0715ff8;
    // Expected results in arrival order
    int expOut0 [$];
    int expOut1 [$];
    bit expOv0 [$];
    bit expOv1 [$];
    int expCycle [$];
    int cycleIndex = 0;
    int gotOut0;
    int gotOut1;
    int rowOut0 [NumRows];
    int rowOut1 [NumRows];
    int satMaxSeen [2];
    int satMinSeen [2];
    int s0;
    int s1;

    always #20 Clk = ~Clk;

    halfBandDecimator u_dut
    (
        .Clk       (Clk),
        .Reset     (Reset),
        .inStrobe  (inStrobe),
        .in0       (in0),
        .in1       (in1),
        .out0      (out0),
        .out1      (out1),
        .overflow0 (overflow0),
        .overflow1 (overflow1),
        .outStrobe (outStrobe)
    );

    bind halfBandDecimator halfBandDecimatorChecker uChecker
    (
        .Clk       (Clk),
        .Reset     (Reset),
        .inStrobe  (inStrobe),
        .outStrobe (outStrobe),
        .out0      (out0),
        .out1      (out1),
        .overflow0 (overflow0),
        .overflow1 (overflow1)
    );

    //////////////////////////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////////////////////////

    task automatic failNow();
        $display("** FAIL **");
        $fatal(1, "stopped on first error");
    endtask

    task automatic mismatchError(input string name, input int got, input int want);
        $display("error: time %0t ns, %s = %0d, expected %0d", $time, name, got, want);
        failNow();
    endtask

    task automatic stopWithMessage(input string what);
        $display("%s (time %0t ns)", what, $time);
        failNow();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int pickSample(input int kind, input int amp, input int pairIdx);
        int unsigned r;
        // Impulse on the first producing pair so it walks the even taps
        if (kind == KindImpulse)
            return (pairIdx == 1) ? amp : 0;
        if (kind == KindConstant)
            return amp;
        // Upper bits are the better ones
        r = lcgNext() >> 8;
        return int'(r % (2 * amp)) - amp;
    endfunction

    // Folded pairs plus center tap times 2^15
    function automatic longint filterSum(input int ch);
        longint acc;
        acc = longint'(hist[ch][23]) * 32768;
        for (int k = 0; k < 12; k++)
        begin
            acc = acc + longint'(PairCoef[k]) * (hist[ch][2*k] + hist[ch][NumTaps-1-2*k]);
        end
        return acc;
    endfunction

    task automatic roundModel(input longint acc, output int value, output bit ovf);
        longint rounded;
        // Half an LSB of bit 17 and one less below zero
        rounded = (acc < 0) ? acc + 65535 : acc + 65536;
        ovf = 1'b1;
        // Bits 33 to 30 agree only inside +-2^30
        if (rounded >= 1073741824)
            value = 8191;
        else if (rounded < -1073741824)
            value = -8192;
        else
        begin
            value = int'(rounded >>> 17);
            ovf = 1'b0;
        end
    endtask

    task automatic updateModel(input int x0, input int x1, input int dueCycle);
        int value;
        bit ovf;
        for (int i = NumTaps - 1; i > 0; i--)
        begin
            hist[0][i] = hist[0][i-1];
            hist[1][i] = hist[1][i-1];
        end
        hist[0][0] = x0;
        hist[1][0] = x1;
        // Every second pair produces
        if (refPhase)
        begin
            roundModel(filterSum(0), value, ovf);
            expOut0.push_back(value);
            expOv0.push_back(ovf);
            roundModel(filterSum(1), value, ovf);
            expOut1.push_back(value);
            expOv1.push_back(ovf);
            expCycle.push_back(dueCycle);
        end
        refPhase = !refPhase;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Driver and monitor
    //////////////////////////////////////////////////////////////////////

    task automatic sendPair(input int x0, input int x1, input int gap);
        @(posedge Clk);
        inStrobe <= 1'b1;
        in0 <= 15'(x0);
        in1 <= 15'(x1);
        // Strobe is seen at the next falling edge
        updateModel(x0, x1, cycleIndex + 1 + OutLatency);
        repeat (gap - 1)
        begin
            @(posedge Clk);
            inStrobe <= 1'b0;
        end
    endtask

    task automatic waitForDrain();
        int waited;
        waited = 0;
        while (expCycle.size() != 0)
        begin
            @(posedge Clk);
            waited++;
            assert (waited <= DrainTimeout)
            else
                stopWithMessage("timeout waiting for outStrobe");
        end
    endtask

    function automatic void noteSaturation(input int ch, input int value, input logic ovf);
        if (ovf && value == 8191)
            satMaxSeen[ch]++;
        if (ovf && value == -8192)
            satMinSeen[ch]++;
    endfunction

    // Outputs compared mid-cycle
    always @(negedge Clk)
    begin
        cycleIndex = cycleIndex + 1;
        assert (u_dut.uChecker.violationCount == 0)
        else
            stopWithMessage("protocol checker reported a violation");
        if (outStrobe)
        begin
            assert (expCycle.size() != 0)
            else
                stopWithMessage("outStrobe pulsed with no result expected");
            gotOut0 = int'($signed(out0));
            gotOut1 = int'($signed(out1));
            assert (cycleIndex == expCycle[0])
            else
                mismatchError("outStrobe cycle", cycleIndex, expCycle[0]);
            assert (gotOut0 == expOut0[0])
            else
                mismatchError("out0", gotOut0, expOut0[0]);
            assert (gotOut1 == expOut1[0])
            else
                mismatchError("out1", gotOut1, expOut1[0]);
            assert (overflow0 == expOv0[0])
            else
                mismatchError("overflow0", int'(overflow0), int'(expOv0[0]));
            assert (overflow1 == expOv1[0])
            else
                mismatchError("overflow1", int'(overflow1), int'(expOv1[0]));
            noteSaturation(0, gotOut0, overflow0);
            noteSaturation(1, gotOut1, overflow1);
            void'(expOut0.pop_front());
            void'(expOut1.pop_front());
            void'(expOv0.pop_front());
            void'(expOv1.pop_front());
            void'(expCycle.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        Reset = 1'b1;
        inStrobe = 1'b0;
        in0 = '0;
        in1 = '0;
        repeat (3) @(posedge Clk);
        Reset <= 1'b0;
        @(negedge Clk);
        // Everything idle out of reset
        assert (out0 == '0 && out1 == '0)
        else
            stopWithMessage("outputs not zero after reset");
        assert (!overflow0 && !overflow1 && !outStrobe)
        else
            stopWithMessage("flags or strobe set after reset");
        for (int row = 0; row < NumRows; row++)
        begin
            for (int p = 0; p < RowPairs[row]; p++)
            begin
                s0 = pickSample(RowKind[row], RowAmp0[row], p);
                s1 = pickSample(RowKind[row], RowAmp1[row], p);
                sendPair(s0, s1, RowGap[row]);
            end
            waitForDrain();
            @(negedge Clk);
            rowOut0[row] = int'($signed(out0));
            rowOut1[row] = int'($signed(out1));
        end
        // Symmetric rounding gives mirrored settled values
        assert (rowOut0[MirrorNeg] == -rowOut0[MirrorPos])
        else
            mismatchError("out0 mirrored", rowOut0[MirrorNeg], -rowOut0[MirrorPos]);
        assert (rowOut1[MirrorNeg] == -rowOut1[MirrorPos])
        else
            mismatchError("out1 mirrored", rowOut1[MirrorNeg], -rowOut1[MirrorPos]);
        assert (rowOut0[MirrorPos] != 0 && rowOut1[MirrorPos] != 0)
        else
            stopWithMessage("small constants settled at zero");
        for (int ch = 0; ch < 2; ch++)
        begin
            assert (satMaxSeen[ch] > 0 && satMinSeen[ch] > 0)
            else
                stopWithMessage("a channel never saturated both ways");
        end
        assert (expCycle.size() == 0)
        else
            stopWithMessage("expected results left over at the end");
        $display("** PASS **");
        $finish;
    end

endmodule

// File: dv/halfBandDecimatorChecker.sv
`timescale 1ns/1ps

module halfBandDecimatorChecker
(
    input logic                            Clk,
    input logic                            Reset,
    input logic                            inStrobe,
    input logic                            outStrobe,
    input logic [hbDecimPkg::OutWidth-1:0] out0,
    input logic [hbDecimPkg::OutWidth-1:0] out1,
    input logic                            overflow0,
    input logic                            overflow1
);

    // Failed properties so far, polled by the testbench monitor
    int violationCount = 0;

    //////////////////////////////////////////////////////////////////////
    // Strobe protocol
    //////////////////////////////////////////////////////////////////////

    // Input pairs need at least two cycles between strobes
    inStrobeSpacing: assert property (@(posedge Clk) disable iff (Reset)
        inStrobe |=> !inStrobe)
    else
    begin
        violationCount = violationCount + 1;
        $error("inStrobe high in two consecutive cycles");
    end

    // One result pulse per producing pair
    outStrobePulse: assert property (@(posedge Clk) disable iff (Reset)
        outStrobe |=> !outStrobe)
    else
    begin
        violationCount = violationCount + 1;
        $error("outStrobe high in two consecutive cycles");
    end

    //////////////////////////////////////////////////////////////////////
    // Saturation
    //////////////////////////////////////////////////////////////////////

    // Overflow only ever comes with a clamped value
    clampOut0: assert property (@(posedge Clk) disable iff (Reset)
        overflow0 |-> (out0 == hbDecimPkg::SatMax || out0 == hbDecimPkg::SatMin))
    else
    begin
        violationCount = violationCount + 1;
        $error("overflow0 set while out0 is not a saturation value");
    end

    clampOut1: assert property (@(posedge Clk) disable iff (Reset)
        overflow1 |-> (out1 == hbDecimPkg::SatMax || out1 == hbDecimPkg::SatMin))
    else
    begin
        violationCount = violationCount + 1;
        $error("overflow1 set while out1 is not a saturation value");
    end

endmodule

// File: rtl/halfBandDecimator.sv
`timescale 1ns/1ps

module halfBandDecimator
(
    input  logic                                      Clk,
    input  logic                                      Reset,
    input  logic                                      inStrobe,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] in0,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] in1,
    output logic [hbDecimPkg::OutWidth-1:0]           out0,
    output logic [hbDecimPkg::OutWidth-1:0]           out1,
    output logic                                      overflow0,
    output logic                                      overflow1,
    output logic                                      outStrobe
);

    //////////////////////////////////////////////////////////////////////
    // Internal paths
    //////////////////////////////////////////////////////////////////////

    // Serialised sample stream
    logic wordStrobe;
    logic signed [hbDecimPkg::SampleWidth-1:0] word;
    logic wordChannel;
    // Full-precision filter result
    logic sumStrobe;
    logic signed [hbDecimPkg::AccWidth-1:0] sum;
    logic sumChannel;

    // Pair to word stream
    sampleInterleaver uInterleaver
    (
        .Clk         (Clk),
        .Reset       (Reset),
        .inStrobe    (inStrobe),
        .in0         (in0),
        .in1         (in1),
        .wordStrobe  (wordStrobe),
        .word        (word),
        .wordChannel (wordChannel)
    );

    // Delay lines and multiply-accumulate
    halfBandCore uCore
    (
        .Clk         (Clk),
        .Reset       (Reset),
        .wordStrobe  (wordStrobe),
        .word        (word),
        .wordChannel (wordChannel),
        .sumStrobe   (sumStrobe),
        .sum         (sum),
        .sumChannel  (sumChannel)
    );

    // Output stage
    roundSaturate uRound
    (
        .Clk        (Clk),
        .Reset      (Reset),
        .sumStrobe  (sumStrobe),
        .sum        (sum),
        .sumChannel (sumChannel),
        .out0       (out0),
        .out1       (out1),
        .overflow0  (overflow0),
        .overflow1  (overflow1),
        .outStrobe  (outStrobe)
    );

endmodule

// File: rtl/roundSaturate.sv
`timescale 1ns/1ps

module roundSaturate
(
    input  logic                                   Clk,
    input  logic                                   Reset,
    input  logic                                   sumStrobe,
    input  logic signed [hbDecimPkg::AccWidth-1:0] sum,
    input  logic                                   sumChannel,
    output logic [hbDecimPkg::OutWidth-1:0]        out0,
    output logic [hbDecimPkg::OutWidth-1:0]        out1,
    output logic                                   overflow0,
    output logic                                   overflow1,
    output logic                                   outStrobe
);

    localparam int AW = hbDecimPkg::AccWidth;

    logic [AW-1:0] rounded;
    // Bits that must all match the kept sign bit
    logic [AW-1:hbDecimPkg::GuardMsb] guard;
    logic inRange;
    logic [hbDecimPkg::OutWidth-1:0] result;

    // Symmetric rounding, half away from zero
    assign rounded = sum + (sum[AW-1] ? hbDecimPkg::RoundNeg : hbDecimPkg::RoundPos);
    assign guard = rounded[AW-1:hbDecimPkg::GuardMsb];
    assign inRange = (&guard) | ~(|guard);

    // Clamp by the sign of the wide sum
    always_comb
    begin
        if (inRange)
            result = rounded[hbDecimPkg::GuardMsb:hbDecimPkg::OutLsb];
        else if (rounded[AW-1])
            result = hbDecimPkg::SatMin;
        else
            result = hbDecimPkg::SatMax;
    end

    //////////////////////////////////////////////////////////////////////
    // Per-channel output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            out0 <= '0;
            out1 <= '0;
            overflow0 <= 1'b0;
            overflow1 <= 1'b0;
            outStrobe <= 1'b0;
        end
        else
        begin
            if (sumStrobe && !sumChannel)
            begin
                out0 <= result;
                overflow0 <= ~inRange;
            end
            if (sumStrobe && sumChannel)
            begin
                out1 <= result;
                overflow1 <= ~inRange;
            end
            // Channel 1 lands last, so both outputs are valid here
            outStrobe <= sumStrobe & sumChannel;
        end
    end

endmodule

// File: rtl/halfBandCore.sv
`timescale 1ns/1ps

module halfBandCore
(
    input  logic                                      Clk,
    input  logic                                      Reset,
    input  logic                                      wordStrobe,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] word,
    input  logic                                      wordChannel,
    output logic                                      sumStrobe,
    output logic signed [hbDecimPkg::AccWidth-1:0]    sum,
    output logic                                      sumChannel
);

    localparam int SW = hbDecimPkg::SampleWidth;
    localparam int NT = hbDecimPkg::NumTaps;
    localparam int CenterExt = hbDecimPkg::AccWidth - SW - hbDecimPkg::CenterShift;

    //////////////////////////////////////////////////////////////////////
    // Delay lines, one per channel
    //////////////////////////////////////////////////////////////////////

    // Index 0 holds the newest sample
    logic signed [SW-1:0] lines [2][NT];
    logic signed [SW-1:0] tapSel [NT];
    logic signed [SW-1:0] centerReg;
    logic signed [hbDecimPkg::AccWidth-1:0] products [hbDecimPkg::NumPairs];
    logic signed [hbDecimPkg::AccWidth-1:0] centerTerm;
    logic signed [hbDecimPkg::AccWidth-1:0] sumNext;
    // Set once the first pair of a decimated couple is in
    logic phase;
    logic selValid;
    logic selCh;
    logic prodValid;
    logic prodCh;

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            for (int c = 0; c < 2; c++)
            begin
                for (int i = 0; i < NT; i++)
                begin
                    lines[c][i] <= '0;
                end
            end
        end
        else if (wordStrobe)
        begin
            // Only the tagged channel moves
            lines[wordChannel][0] <= word;
            for (int i = 1; i < NT; i++)
            begin
                lines[wordChannel][i] <= lines[wordChannel][i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Phase and pipeline control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            phase <= 1'b0;
            selValid <= 1'b0;
            selCh <= 1'b0;
            prodValid <= 1'b0;
            prodCh <= 1'b0;
            sumStrobe <= 1'b0;
            sumChannel <= 1'b0;
        end
        else
        begin
            // Flip after each complete pair
            if (wordStrobe && wordChannel)
                phase <= ~phase;
            // Produce only on the second pair
            selValid <= wordStrobe & phase;
            selCh <= wordChannel;
            prodValid <= selValid;
            prodCh <= selCh;
            sumStrobe <= prodValid;
            sumChannel <= prodCh;
        end
    end

    // Taps come from the line written last cycle
    always_comb
    begin
        for (int i = 0; i < NT; i++)
        begin
            tapSel[i] = lines[selCh][i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tap slices, center tap and sum
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < hbDecimPkg::NumPairs; k++)
    begin : gTap
        tapSlice #(.PairIndex(k)) uSlice
        (
            .Clk     (Clk),
            .Reset   (Reset),
            .early   (tapSel[2*k]),
            .late    (tapSel[NT-1-2*k]),
            .product (products[k])
        );
    end

    // Center sample delayed to line up with the products
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            centerReg <= '0;
        else
            centerReg <= tapSel[hbDecimPkg::CenterTap];
    end

    assign centerTerm = {{CenterExt{centerReg[SW-1]}}, centerReg,
                         {hbDecimPkg::CenterShift{1'b0}}};

    always_comb
    begin
        sumNext = centerTerm;
        for (int k = 0; k < hbDecimPkg::NumPairs; k++)
        begin
            sumNext = sumNext + products[k];
        end
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            sum <= '0;
        else if (prodValid)
            sum <= sumNext;
    end

endmodule

// File: rtl/tapSlice.sv
`timescale 1ns/1ps

module tapSlice
#(
    parameter int PairIndex = 0
)
(
    input  logic                                      Clk,
    input  logic                                      Reset,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] early,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] late,
    output logic signed [hbDecimPkg::AccWidth-1:0]    product
);

    localparam int SumWidth = hbDecimPkg::SampleWidth + 1;
    localparam int MultWidth = SumWidth + hbDecimPkg::CoefWidth;
    // Sign bits needed to reach accumulator width
    localparam int ExtBits = hbDecimPkg::AccWidth - MultWidth;
    localparam logic signed [hbDecimPkg::CoefWidth-1:0] Coef = hbDecimPkg::Coefs[PairIndex];

    // Pre-add of the symmetric pair, one extra bit
    logic signed [SumWidth-1:0] preAdd;
    logic signed [MultWidth-1:0] mult;

    assign preAdd = early + late;
    assign mult = preAdd * Coef;

    // Single product register, like the DSP output stage
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            product <= '0;
        else
            product <= {{ExtBits{mult[MultWidth-1]}}, mult};
    end

endmodule

// File: rtl/sampleInterleaver.sv
`timescale 1ns/1ps

module sampleInterleaver
(
    input  logic                                   Clk,
    input  logic                                   Reset,
    input  logic                                   inStrobe,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] in0,
    input  logic signed [hbDecimPkg::SampleWidth-1:0] in1,
    output logic                                   wordStrobe,
    output logic signed [hbDecimPkg::SampleWidth-1:0] word,
    output logic                                   wordChannel
);

    // Channel-1 sample parked while channel 0 goes out
    logic signed [hbDecimPkg::SampleWidth-1:0] hold1;
    // Channel-1 word still owed
    logic pending;

    // Payload capture only
    always_ff @(posedge Clk)
    begin
        if (inStrobe)
        begin
            hold1 <= in1;
        end
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            wordStrobe <= 1'b0;
            word <= '0;
            wordChannel <= 1'b0;
            pending <= 1'b0;
        end
        else
        begin
            // One word per cycle, channel 0 first
            wordStrobe <= inStrobe | pending;
            if (inStrobe)
            begin
                word <= in0;
                wordChannel <= 1'b0;
                pending <= 1'b1;
            end
            else if (pending)
            begin
                word <= hold1;
                wordChannel <= 1'b1;
                pending <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/hbDecimPkg.sv
package hbDecimPkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////

    // Input sample, two's complement
    localparam int SampleWidth = 15;
    localparam int OutWidth = 14;
    localparam int CoefWidth = 17;
    // Wide enough for the full tap sum plus guard bits
    localparam int AccWidth = 34;

    //////////////////////////////////////////////////////////////////////
    // Filter shape
    //////////////////////////////////////////////////////////////////////

    localparam int NumTaps = 47;
    // Only even taps are non-zero, folded into pairs
    localparam int NumPairs = 12;
    localparam int CenterTap = 23;
    // Center coefficient is 2^15, done as a shift
    localparam int CenterShift = 15;

    // Pair k covers taps 2k and NumTaps-1-2k
    localparam logic signed [CoefWidth-1:0] Coefs [NumPairs] = '{
        -17'sd8, 17'sd27, -17'sd68, 17'sd146, -17'sd281, 17'sd499,
        -17'sd837, 17'sd1353, -17'sd2161, 17'sd3547, -17'sd6561, 17'sd20727
    };

    //////////////////////////////////////////////////////////////////////
    // Rounding and saturation
    //////////////////////////////////////////////////////////////////////

    // Half an output LSB, biased down by one for negative sums
    localparam logic [AccWidth-1:0] RoundPos = 34'h10000;
    localparam logic [AccWidth-1:0] RoundNeg = 34'h0FFFF;
    localparam int OutLsb = 17;
    localparam int GuardMsb = 30;
    localparam logic signed [OutWidth-1:0] SatMax = 14'sd8191;
    localparam logic signed [OutWidth-1:0] SatMin = -14'sd8192;

endpackage
